//--- hw/alu_pkg.sv
// shared types for the RV32I execute unit, only OP, OP-IMM and LUI encodings are described here
package alu_pkg;

    // ########################################################################
    // widths
    // ########################################################################

    localparam int XLEN      = 32;
    localparam int NREG_LOG2 = 5;

    // ########################################################################
    // major opcodes
    // ########################################################################

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // ALU operation codes, PASS returns operand b unchanged
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_XOR  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_AND  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_PASS = 4'd10
    } alu_op_e;

    // ########################################################################
    // instruction views
    // ########################################################################

    typedef struct packed {
        logic [6:0]           funct7;
        logic [NREG_LOG2-1:0] rs2;
        logic [NREG_LOG2-1:0] rs1;
        logic [2:0]           funct3;
        logic [NREG_LOG2-1:0] rd;
        logic [6:0]           opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]          imm12;
        logic [NREG_LOG2-1:0] rs1;
        logic [2:0]           funct3;
        logic [NREG_LOG2-1:0] rd;
        logic [6:0]           opcode;
    } i_fmt_t;

    typedef union packed {
        logic [XLEN-1:0] raw;
        r_fmt_t          r;
        i_fmt_t          i;
    } instr_u;

    // decoder to datapath
    typedef struct packed {
        alu_op_e              alu_op;
        logic                 use_imm;     // operand b from imm
        logic                 use_zero_a;  // operand a forced to zero
        logic [XLEN-1:0]      imm;
        logic [NREG_LOG2-1:0] rs1;
        logic [NREG_LOG2-1:0] rs2;
        logic [NREG_LOG2-1:0] rd;
        logic                 wr_en;
    } exec_ctrl_t;

    typedef struct packed {
        logic [NREG_LOG2-1:0] rd;
        logic [XLEN-1:0]      data;
        logic                 illegal;
    } wb_t;

endpackage

//--- hw/cla_adder.sv
// 32-bit adder from eight 4-bit lookahead groups with rippled group carries, no carry out
module cla_adder (
    input  logic [alu_pkg::XLEN-1:0] a_i,
    input  logic [alu_pkg::XLEN-1:0] b_i,
    input  logic                     carry_i,
    output logic [alu_pkg::XLEN-1:0] sum_o
);

    logic [alu_pkg::XLEN-1:0]   gen;
    logic [alu_pkg::XLEN-1:0]   prop;
    logic [alu_pkg::XLEN/4-1:0] grp_c;  // carry into each group

    assign gen      = a_i & b_i;
    assign prop     = a_i ^ b_i;
    assign grp_c[0] = carry_i;

    for (genvar k = 0; k < alu_pkg::XLEN / 4; k++) begin : g_grp
        logic [3:0] gg;
        logic [3:0] pp;
        logic [3:0] c;

        assign gg = gen[4*k +: 4];
        assign pp = prop[4*k +: 4];

        // lookahead inside the group
        assign c[0] = grp_c[k];
        assign c[1] = gg[0] | (pp[0] & c[0]);
        assign c[2] = gg[1] | (pp[1] & gg[0]) | (pp[1] & pp[0] & c[0]);
        assign c[3] = gg[2] | (pp[2] & gg[1]) | (pp[2] & pp[1] & gg[0])
                    | (pp[2] & pp[1] & pp[0] & c[0]);

        assign sum_o[4*k +: 4] = pp ^ c;

        // group generate and propagate feed the next group
        if (k < alu_pkg::XLEN / 4 - 1) begin : g_next
            assign grp_c[k+1] = gg[3]
                              | (pp[3] & gg[2])
                              | (pp[3] & pp[2] & gg[1])
                              | (pp[3] & pp[2] & pp[1] & gg[0])
                              | ((&pp) & c[0]);
        end
    end

endmodule

//--- hw/alu.sv
// combinational ALU, shifts use only the low five bits of b, clk_i feeds the op check alone
module alu (
    input  logic                     clk_i,
    input  alu_pkg::alu_op_e         op_i,
    input  logic [alu_pkg::XLEN-1:0] a_i,
    input  logic [alu_pkg::XLEN-1:0] b_i,
    output logic [alu_pkg::XLEN-1:0] result_o
);

    logic                     is_sub;
    logic [alu_pkg::XLEN-1:0] b_add;
    logic [alu_pkg::XLEN-1:0] sum;
    logic [4:0]               shamt;
    logic                     lt_s;
    logic                     lt_u;

    // ########################################################################
    // adder path
    // ########################################################################

    assign is_sub = (op_i == alu_pkg::ALU_SUB);
    assign b_add  = is_sub ? ~b_i : b_i;  // a + ~b + 1

    cla_adder u_cla (
        .a_i     (a_i),
        .b_i     (b_add),
        .carry_i (is_sub),
        .sum_o   (sum)
    );

    // ########################################################################
    // logic, shift and compare
    // ########################################################################

    assign shamt = b_i[4:0];
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;

    always_comb begin
        case (op_i)
            alu_pkg::ALU_ADD,
            alu_pkg::ALU_SUB:  result_o = sum;
            alu_pkg::ALU_XOR:  result_o = a_i ^ b_i;
            alu_pkg::ALU_OR:   result_o = a_i | b_i;
            alu_pkg::ALU_AND:  result_o = a_i & b_i;
            alu_pkg::ALU_SLL:  result_o = a_i << shamt;
            alu_pkg::ALU_SRL:  result_o = a_i >> shamt;
            alu_pkg::ALU_SRA:  result_o = $signed(a_i) >>> shamt;
            alu_pkg::ALU_SLT:  result_o = {{(alu_pkg::XLEN-1){1'b0}}, lt_s};
            alu_pkg::ALU_SLTU: result_o = {{(alu_pkg::XLEN-1){1'b0}}, lt_u};
            alu_pkg::ALU_PASS: result_o = b_i;
            default:           result_o = '0;
        endcase
    end

    // the decoder only ever hands over a defined operation
    a_op_known: assert property (
        @(posedge clk_i) !$isunknown(op_i) && (op_i <= alu_pkg::ALU_PASS)
    ) else $error("alu: undefined operation code %0h", op_i);

endmodule

//--- hw/reg_file.sv
// 32 x 32 register file, reads are combinational, writes land on the clock edge, x0 reads zero
module reg_file (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic [alu_pkg::NREG_LOG2-1:0] rs1_i,
    input  logic [alu_pkg::NREG_LOG2-1:0] rs2_i,
    output logic [alu_pkg::XLEN-1:0]      rs1_data_o,
    output logic [alu_pkg::XLEN-1:0]      rs2_data_o,
    input  logic                          we_i,
    input  logic [alu_pkg::NREG_LOG2-1:0] rd_i,
    input  logic [alu_pkg::XLEN-1:0]      rd_data_i
);

    logic [alu_pkg::XLEN-1:0] regs [2**alu_pkg::NREG_LOG2];

    // entry 0 is cleared by reset and never written afterwards
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < 2**alu_pkg::NREG_LOG2; k++) begin
                regs[k] <= '0;
            end
        end else if (we_i && (rd_i != '0)) begin  // x0 writes dropped
            regs[rd_i] <= rd_data_i;
        end
    end

    assign rs1_data_o = regs[rs1_i];
    assign rs2_data_o = regs[rs2_i];

    // holds only while writes to index 0 are kept out of the array
    a_x0_zero: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        ((rs1_i == '0) |-> (rs1_data_o == '0)) and ((rs2_i == '0) |-> (rs2_data_o == '0))
    ) else $error("reg_file: x0 read back nonzero");

endmodule

//--- hw/instr_decoder.sv
// decodes OP, OP-IMM and LUI only, everything else is flagged illegal, clk_i feeds the check alone
module instr_decoder (
    input  logic                clk_i,
    input  alu_pkg::instr_u     instr_i,
    output alu_pkg::exec_ctrl_t ctrl_o,
    output logic                illegal_o
);

    alu_pkg::r_fmt_t r_w;
    alu_pkg::i_fmt_t i_w;

    // funct3 mapping shared by OP and OP-IMM
    function automatic alu_pkg::alu_op_e base_op(input logic [2:0] funct3);
        alu_pkg::alu_op_e op;
        case (funct3)
            3'b000:  op = alu_pkg::ALU_ADD;
            3'b001:  op = alu_pkg::ALU_SLL;
            3'b010:  op = alu_pkg::ALU_SLT;
            3'b011:  op = alu_pkg::ALU_SLTU;
            3'b100:  op = alu_pkg::ALU_XOR;
            3'b101:  op = alu_pkg::ALU_SRL;
            3'b110:  op = alu_pkg::ALU_OR;
            default: op = alu_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign r_w = instr_i.r;
    assign i_w = instr_i.i;

    always_comb begin
        ctrl_o        = '0;
        ctrl_o.alu_op = alu_pkg::ALU_ADD;
        ctrl_o.rs1    = r_w.rs1;
        ctrl_o.rs2    = r_w.rs2;
        ctrl_o.rd     = r_w.rd;
        ctrl_o.imm    = {{(alu_pkg::XLEN-12){i_w.imm12[11]}}, i_w.imm12};
        illegal_o     = 1'b0;

        case (r_w.opcode)
            alu_pkg::OPC_OP: begin
                ctrl_o.alu_op = base_op(r_w.funct3);
                ctrl_o.wr_en  = 1'b1;
                if (r_w.funct7 == 7'b0100000) begin
                    if (r_w.funct3 == 3'b000) begin
                        ctrl_o.alu_op = alu_pkg::ALU_SUB;
                    end else if (r_w.funct3 == 3'b101) begin
                        ctrl_o.alu_op = alu_pkg::ALU_SRA;
                    end else begin
                        illegal_o = 1'b1;
                    end
                end else if (r_w.funct7 != 7'b0) begin
                    illegal_o = 1'b1;
                end
            end
            alu_pkg::OPC_OP_IMM: begin
                ctrl_o.alu_op  = base_op(i_w.funct3);  // ADDI stays ADD
                ctrl_o.use_imm = 1'b1;
                ctrl_o.wr_en   = 1'b1;
                if (i_w.funct3 == 3'b001) begin
                    illegal_o = (i_w.imm12[11:5] != 7'b0);
                end else if (i_w.funct3 == 3'b101) begin
                    if (i_w.imm12[11:5] == 7'b0100000) begin
                        ctrl_o.alu_op = alu_pkg::ALU_SRA;  // bit 30 picks SRAI
                    end else if (i_w.imm12[11:5] != 7'b0) begin
                        illegal_o = 1'b1;
                    end
                end
            end
            alu_pkg::OPC_LUI: begin
                ctrl_o.alu_op     = alu_pkg::ALU_PASS;
                ctrl_o.use_imm    = 1'b1;
                ctrl_o.use_zero_a = 1'b1;
                ctrl_o.imm        = {instr_i.raw[31:12], 12'b0};
                ctrl_o.wr_en      = 1'b1;
            end
            default: illegal_o = 1'b1;
        endcase

        if (illegal_o) begin
            ctrl_o.wr_en = 1'b0;
        end
    end

    // with funct7 zero every OP and OP-IMM encoding is a legal instruction
    a_zero_f7_legal: assert property (
        @(posedge clk_i)
        ((r_w.opcode == alu_pkg::OPC_OP) || (r_w.opcode == alu_pkg::OPC_OP_IMM))
            && (r_w.funct7 == 7'b0) |-> !illegal_o
    ) else $error("decoder: legal encoding %08h flagged illegal", instr_i.raw);

endmodule

//--- hw/int_exec_top.sv
// one instruction per cycle, write-back reported one cycle after the strobe, no stall or forwarding
module int_exec_top (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     instr_valid_i,
    input  logic [alu_pkg::XLEN-1:0] instr_i,
    output logic                     wb_valid_o,
    output alu_pkg::wb_t             wb_o
);

    alu_pkg::instr_u                instr_w;
    alu_pkg::exec_ctrl_t            ctrl;
    logic                           illegal;
    logic [alu_pkg::XLEN-1:0]       rs1_data;
    logic [alu_pkg::XLEN-1:0]       rs2_data;
    logic [alu_pkg::XLEN-1:0]       op_a;
    logic [alu_pkg::XLEN-1:0]       op_b;
    logic [alu_pkg::XLEN-1:0]       alu_res;
    logic                           rf_we;
    logic [alu_pkg::NREG_LOG2-1:0]  rd_q;
    logic [alu_pkg::XLEN-1:0]       data_q;
    logic                           illegal_q;

    assign instr_w.raw = instr_i;

    instr_decoder u_dec (
        .clk_i     (clk_i),
        .instr_i   (instr_w),
        .ctrl_o    (ctrl),
        .illegal_o (illegal)
    );

    reg_file u_rf (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_i      (ctrl.rs1),
        .rs2_i      (ctrl.rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rf_we),
        .rd_i       (ctrl.rd),
        .rd_data_i  (alu_res)
    );

    assign op_a = ctrl.use_zero_a ? '0 : rs1_data;  // LUI
    assign op_b = ctrl.use_imm ? ctrl.imm : rs2_data;

    alu u_alu (
        .clk_i    (clk_i),
        .op_i     (ctrl.alu_op),
        .a_i      (op_a),
        .b_i      (op_b),
        .result_o (alu_res)
    );

    assign rf_we = instr_valid_i & ctrl.wr_en;

    // ########################################################################
    // write-back report
    // ########################################################################

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_o <= 1'b0;
            illegal_q  <= 1'b0;
        end else begin
            wb_valid_o <= instr_valid_i;
            illegal_q  <= instr_valid_i & illegal;
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_valid_i) begin
            rd_q   <= ctrl.rd;
            data_q <= illegal ? '0 : alu_res;
        end
    end

    assign wb_o = '{rd: rd_q, data: data_q, illegal: illegal_q};

    // an illegal report must come from a cycle that left the register file alone
    a_illegal_no_write: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        wb_o.illegal |-> !$past(rf_we)
    ) else $error("top: illegal instruction wrote x%0d", wb_o.rd);

endmodule

//--- tb/clk_gen.sv
// free-running clock of period 100, reset held low for the first 8 rising edges then released
module clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #10;
        rst_n_o = 1'b1;  // released away from the edge
    end

endmodule

//--- tb/int_exec_tb.sv
// testbench for int_exec_top, the first mismatch ends the run, random stimulus uses seed 27568
module int_exec_tb;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam int RESET_CYCLES  = 8;
    localparam int N_DIRECTED    = 140;  // directed instructions and idle cycles, upper bound
    localparam int N_RANDOM      = 300;
    localparam int N_GAPS        = N_RANDOM;
    localparam int WATCHDOG_TIME = 100 * (N_DIRECTED + N_RANDOM + N_GAPS + RESET_CYCLES + 50);

    logic         clk;
    logic         rst_n;
    logic         instr_valid;
    logic [31:0]  instr;
    logic         wb_valid;
    alu_pkg::wb_t wb;

    logic [31:0]  model_regs [32];
    alu_pkg::wb_t exp_q [$];

    clk_gen u_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    int_exec_top dut_i (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .wb_valid_o    (wb_valid),
        .wb_o          (wb)
    );

    // ########################################################################
    // encoders and reference model
    // ########################################################################

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [19:0] imm20, input logic [4:0] rd);
        return {imm20, rd, OPC_LUI};
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'($urandom());
    endfunction

    // expected write-back, read against the model registers before this instruction
    function automatic alu_pkg::wb_t ref_wb(input logic [31:0] w);
        logic [6:0]   opc;
        logic [2:0]   f3;
        logic [6:0]   f7;
        logic [31:0]  a;
        logic [31:0]  b;
        logic [31:0]  res;
        logic         alt;
        logic         ill;
        alu_pkg::wb_t r;
        opc = w[6:0];
        f3  = w[14:12];
        f7  = w[31:25];
        a   = model_regs[w[19:15]];
        b   = model_regs[w[24:20]];
        res = '0;
        ill = 1'b0;
        case (opc)
            OPC_OP: begin
                ill = !((f7 == 7'b0)
                      || ((f7 == 7'b0100000) && ((f3 == 3'b000) || (f3 == 3'b101))));
            end
            OPC_OP_IMM: begin
                b = {{20{w[31]}}, w[31:20]};
                if (f3 == 3'b001) begin
                    ill = (f7 != 7'b0);
                end else if (f3 == 3'b101) begin
                    ill = (f7 != 7'b0) && (f7 != 7'b0100000);
                end
            end
            OPC_LUI: res = {w[31:12], 12'b0};
            default: ill = 1'b1;
        endcase
        // bit 30 only matters for OP and for the immediate right shifts
        alt = (f7 == 7'b0100000) && ((opc == OPC_OP) || (f3 == 3'b101));
        if ((opc == OPC_OP) || (opc == OPC_OP_IMM)) begin
            case (f3)
                3'b000:  res = alt ? a - b : a + b;
                3'b001:  res = a << b[4:0];
                3'b010:  res = {31'b0, $signed(a) < $signed(b)};
                3'b011:  res = {31'b0, a < b};
                3'b100:  res = a ^ b;
                3'b101: begin
                    if (alt) begin
                        res = $signed(a) >>> b[4:0];
                    end else begin
                        res = a >> b[4:0];
                    end
                end
                3'b110:  res = a | b;
                default: res = a & b;
            endcase
        end
        r.rd      = w[11:7];
        r.data    = ill ? '0 : res;
        r.illegal = ill;
        return r;
    endfunction

    function automatic logic [31:0] random_legal();
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        int          kind;
        kind = int'($urandom() % 3);
        f3   = 3'($urandom());
        if (kind == 0) begin
            f7 = 7'b0;
            if (((f3 == 3'b000) || (f3 == 3'b101)) && ($urandom() % 2 == 1)) begin
                f7 = 7'b0100000;
            end
            return enc_r(f7, rand_reg(), rand_reg(), f3, rand_reg());
        end else if (kind == 1) begin
            imm = 12'($urandom());
            if (f3 == 3'b001) begin
                imm[11:5] = 7'b0;
            end else if (f3 == 3'b101) begin
                imm[11:5] = ($urandom() % 2 == 1) ? 7'b0100000 : 7'b0;
            end
            return enc_i(imm, rand_reg(), f3, rand_reg());
        end else begin
            return enc_lui(20'($urandom()), rand_reg());
        end
    endfunction

    // ########################################################################
    // driving and checking
    // ########################################################################

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("ERROR at time %0t: %s is %08h, expected %08h", $time, what, got, want);
            $display("Test failures found");
            $fatal(1, "value mismatch on %s", what);
        end
    endtask

    task automatic send(input logic [31:0] w);
        alu_pkg::wb_t expected;
        @(posedge clk);
        #10;
        expected    = ref_wb(w);
        instr_valid = 1'b1;
        instr       = w;
        exp_q.push_back(expected);
        if (!expected.illegal && (expected.rd != 5'd0)) begin
            model_regs[expected.rd] = expected.data;
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #10;
        instr_valid = 1'b0;
        instr       = $urandom();  // junk that must not be executed
    endtask

    initial begin : stimulus
        logic [2:0] f3;
        logic [6:0] f7;
        instr_valid = 1'b0;
        instr       = '0;
        void'($urandom(27568));
        for (int k = 0; k < 32; k++) begin
            model_regs[k] = '0;
        end
        @(posedge rst_n);
        repeat (4) idle_cycle();

        send(enc_r(7'b0, 5'd0, 5'd0, 3'b000, 5'd5));  // ADD x5, x0, x0

        // known and random register contents
        send(enc_lui(20'h12345, 5'd1));
        send(enc_i(12'h678, 5'd1, 3'b000, 5'd1));
        send(enc_i(12'hfff, 5'd0, 3'b000, 5'd2));
        send(enc_i(12'h800, 5'd0, 3'b000, 5'd3));
        for (int r = 4; r < 32; r++) begin
            send(enc_lui(20'($urandom()), 5'(r)));
            send(enc_i(12'($urandom()), 5'(r), 3'b000, 5'(r)));
        end

        // every R-type operation, then a dependent chain
        for (int k = 0; k < 10; k++) begin
            f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'b000 : 3'b101);
            f7 = (k < 8) ? 7'b0 : 7'b0100000;
            send(enc_r(f7, rand_reg(), rand_reg(), f3, rand_reg()));
        end
        send(enc_r(7'b0, 5'd2, 5'd1, 3'b000, 5'd10));
        send(enc_r(7'b0100000, 5'd3, 5'd10, 3'b000, 5'd11));
        send(enc_r(7'b0, 5'd10, 5'd11, 3'b100, 5'd12));
        send(enc_lui(20'h80000, 5'd20));
        send(enc_i(12'd8, 5'd0, 3'b000, 5'd21));
        send(enc_r(7'b0100000, 5'd21, 5'd20, 3'b101, 5'd22));  // SRA
        send(enc_r(7'b0, 5'd21, 5'd20, 3'b101, 5'd23));        // SRL
        send(enc_r(7'b0, 5'd21, 5'd20, 3'b010, 5'd24));        // SLT
        send(enc_r(7'b0, 5'd21, 5'd20, 3'b011, 5'd25));        // SLTU

        // immediate shifts and compares, x0 writes
        send(enc_i({7'b0, 5'd5}, 5'd1, 3'b001, 5'd26));
        send(enc_i({7'b0, 5'd4}, 5'd20, 3'b101, 5'd27));
        send(enc_i({7'b0100000, 5'd4}, 5'd20, 3'b101, 5'd28));
        send(enc_i(12'h000, 5'd2, 3'b010, 5'd13));
        send(enc_i(12'hfff, 5'd2, 3'b011, 5'd14));
        send(enc_i(12'h001, 5'd0, 3'b011, 5'd15));
        send(enc_i(12'hfff, 5'd1, 3'b100, 5'd16));
        send(enc_i(12'h0f0, 5'd3, 3'b110, 5'd17));
        send(enc_i(12'h0ff, 5'd1, 3'b111, 5'd18));
        send(enc_i(12'h07b, 5'd1, 3'b000, 5'd0));
        send(enc_r(7'b0, 5'd0, 5'd0, 3'b000, 5'd29));

        // illegal encodings aimed at x1, then read x1 back
        send({12'h002, 5'd1, 3'b010, 5'd1, 7'b0000011});
        send(enc_r(7'b0000001, 5'd2, 5'd1, 3'b000, 5'd1));
        send(enc_i({7'b0000001, 5'd3}, 5'd1, 3'b001, 5'd1));
        send(enc_r(7'b0, 5'd0, 5'd1, 3'b000, 5'd30));

        for (int k = 0; k < N_RANDOM; k++) begin
            send(random_legal());
            if ($urandom() % 4 == 0) begin
                idle_cycle();
            end
        end

        repeat (4) idle_cycle();
        if (exp_q.size() != 0) begin
            $display("%0d expected write-backs were never reported", exp_q.size());
            $display("Test failures found");
            $fatal(1, "write-backs missing at the end of the run");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

    // outputs are sampled on the falling edge, half a cycle after they change
    initial begin : compare
        logic         prev_valid;
        alu_pkg::wb_t expected;
        prev_valid = 1'b0;
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            check("wb_valid_o", {31'b0, wb_valid}, {31'b0, prev_valid});
            if (wb_valid && (exp_q.size() == 0)) begin
                $display("a write-back appeared at time %0t with no instruction pending",
                         $time);
                $display("Test failures found");
                $fatal(1, "unexpected write-back");
            end else if (wb_valid) begin
                expected = exp_q.pop_front();
                check("wb_o.rd", {27'b0, wb.rd}, {27'b0, expected.rd});
                check("wb_o.data", wb.data, expected.data);
                check("wb_o.illegal", {31'b0, wb.illegal}, {31'b0, expected.illegal});
            end
            prev_valid = instr_valid;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_TIME);
        $display("the simulation ran past its time limit without finishing");
        $display("Test failures found");
        $fatal(1, "watchdog timeout");
    end

endmodule

//--- sources.f
hw/alu_pkg.sv
hw/cla_adder.sv
hw/alu.sv
hw/reg_file.sv
hw/instr_decoder.sv
hw/int_exec_top.sv
tb/clk_gen.sv
tb/int_exec_tb.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --top-module int_exec_tb -f sources.f -o int_exec_sim \
    && ./obj_dir/int_exec_sim | tee /dev/stderr | grep -q "All tests passed!" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
exit 0
